//--- all.f
dot_pkg.sv
dot_in_if.sv
vec_fifo.sv
sync_fifo.sv
dot_engine.sv
dot_top.sv
tb_dot.sv

//--- run.sh
#!/bin/sh
# builds and runs the dot-product testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dot -f all.f -Mdir "$obj_dir" -o vtb_dot
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$obj_dir/vtb_dot" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log"
    exit 1
fi

//--- tb_dot.sv
`timescale 1ns/1ps

module tb_dot;

    localparam int LANES          = dot_pkg::LANES;
    localparam int q_bits         = 10;
    localparam int n_directed     = 5;
    localparam int n_random       = 200;
    localparam int n_bp           = 16 + 8 + 2;
    localparam int n_total        = n_directed + n_random + n_bp;
    localparam int timeout_cycles = n_total * 8 + 500;
    localparam logic [31:0] lfsr_taps = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

    // ==========================================================
    // directed table, values in Q22.10
    // ==========================================================

    localparam dot_pkg::sample_t tbl_x [n_directed][LANES] = '{
        '{32'sd1024, 32'sd1024, 32'sd1024},     // 1.0 in every lane
        '{32'sd2048, -32'sd1024, 32'sd512},     // 2.0, -1.0, 0.5
        '{32'sd0, 32'sd0, 32'sd0},
        '{-32'sd1, -32'sd3, -32'sd5},           // tiny negatives floor to -1 each
        '{32'sh7fffffff, 32'sh7fffffff, 32'sd0} // lane sums past 2^31
    };
    localparam dot_pkg::sample_t tbl_y [n_directed][LANES] = '{
        '{32'sd1024, 32'sd1024, 32'sd1024},
        '{32'sd1536, 32'sd3072, -32'sd2048},
        '{32'sd5000, -32'sd7, 32'sd123},
        '{32'sd1, 32'sd1, 32'sd1},
        '{32'sd2048, 32'sd2048, 32'sd0}
    };
    localparam dot_pkg::result_t tbl_exp [n_directed] = '{
        32'sd3072, -32'sd1024, 32'sd0, -32'sd3, -32'sd4
    };

    logic             clock = 1'b0;
    logic             reset = 1'b1;
    dot_pkg::sample_t in_x [LANES];
    dot_pkg::sample_t in_y [LANES];
    logic             in_wr_en;
    logic             in_full;
    dot_pkg::result_t out_data;
    logic             out_empty;
    logic             out_rd_en = 1'b0;

    dot_pkg::sample_t cur_x [LANES];
    dot_pkg::sample_t cur_y [LANES];
    dot_pkg::result_t sb [$];           // expected results in write order
    logic [31:0]      lfsr = 32'h39f0b06c;
    int               rd_mode = 0;      // 0 idle, 1 drain when not empty, 2 read every cycle
    int               err_count = 0;
    int               checks = 0;
    int               received = 0;
    int               accepted = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    int               cycles = 0;

    dot_top dut_i (
        .clock     (clock),
        .reset     (reset),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_wr_en  (in_wr_en),
        .in_full   (in_full),
        .out_data  (out_data),
        .out_empty (out_empty),
        .out_rd_en (out_rd_en)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: no finish after %0d cycles, results still outstanding: %0d",
                     cycles, sb.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ==========================================================
    // reference model and random source
    // ==========================================================

    // only the low 32 bits survive, so lane width above that does not matter
    function automatic dot_pkg::result_t model_dot();
        longint acc;
        longint p;
        acc = 0;
        for (int i = 0; i < LANES; i++) begin
            p   = longint'(cur_x[i]) * longint'(cur_y[i]);
            acc = acc + (p >>> q_bits); // arithmetic shift floors toward minus infinity
        end
        return dot_pkg::result_t'(acc[31:0]);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // sign and 16 bit magnitude
    function automatic dot_pkg::sample_t rand_sample();
        logic [31:0] bits;
        logic [31:0] mag;
        bits = take_bits(17);
        mag  = {16'b0, bits[15:0]};
        return bits[16] ? -$signed(mag) : $signed(mag);
    endfunction

    // ==========================================================
    // drivers and output checker
    // ==========================================================

    // called on a falling edge, returns on the next one
    task automatic send_pair(input dot_pkg::result_t exp, input bit wait_room, output bit taken);
        if (wait_room) begin
            while (in_full) @(negedge clock);
        end
        for (int i = 0; i < LANES; i++) begin
            in_x[i] = cur_x[i];
            in_y[i] = cur_y[i];
        end
        in_wr_en = 1'b1;
        taken    = !in_full; // full only moves on the rising edge
        if (taken) begin
            sb.push_back(exp);
            accepted++;
        end
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    task automatic check_output();
        dot_pkg::result_t exp;
        checks++;
        received++;
        if (sb.size() == 0) begin
            $display("error at %0t: out_data = %0d appeared with no result outstanding",
                     $time, out_data);
            err_count++;
        end else begin
            exp = sb.pop_front();
            if (out_data !== exp) begin
                $display("error at %0t: out_data = %0d, expected %0d", $time, out_data, exp);
                err_count++;
            end
        end
    endtask

    always @(negedge clock) begin
        out_rd_en = 1'b0;
        if (!reset && rd_mode != 0) begin
            if (!out_empty) begin
                check_output();
                out_rd_en = 1'b1;
            end else if (rd_mode == 2) begin
                out_rd_en = 1'b1; // read on an empty FIFO on purpose
            end
        end
    end

    task automatic wait_drain();
        while (sb.size() != 0 || !out_empty) @(negedge clock);
        repeat (4) @(negedge clock);
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (err_count == mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - mark);
        end
    endtask

    // ==========================================================
    // test sequence
    // ==========================================================

    initial begin
        bit taken;
        int mark;
        int dropped;
        int rx_mark;
        in_wr_en = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            in_x[i] = '0;
            in_y[i] = '0;
        end
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        mark = err_count;
        if (out_empty !== 1'b1) begin
            $display("error at %0t: out_empty = %b, expected 1", $time, out_empty);
            err_count++;
        end
        if (in_full !== 1'b0) begin
            $display("error at %0t: in_full = %b, expected 0", $time, in_full);
            err_count++;
        end
        report_test("reset", mark);

        mark    = err_count;
        rd_mode = 1;
        for (int n = 0; n < n_directed; n++) begin
            cur_x = tbl_x[n];
            cur_y = tbl_y[n];
            if (model_dot() !== tbl_exp[n]) begin
                $display("error at %0t: table entry %0d expects %0d but the model gives %0d",
                         $time, n, tbl_exp[n], model_dot());
                err_count++;
            end
            send_pair(tbl_exp[n], 1'b1, taken);
        end
        wait_drain();
        report_test("directed", mark);

        mark = err_count;
        for (int n = 0; n < n_random; n++) begin
            for (int i = 0; i < LANES; i++) begin
                cur_x[i] = rand_sample();
                cur_y[i] = rand_sample();
            end
            send_pair(model_dot(), 1'b1, taken);
        end
        wait_drain();
        report_test("random", mark);

        // output is not read, so the engine stalls and the input FIFO fills
        mark    = err_count;
        rd_mode = 0;
        dropped = 0;
        for (int n = 0; n < n_bp; n++) begin
            for (int i = 0; i < LANES; i++) begin
                cur_x[i] = rand_sample();
                cur_y[i] = rand_sample();
            end
            send_pair(model_dot(), 1'b0, taken);
            if (!taken) begin
                dropped++;
            end
        end
        if (dropped == 0) begin
            $display("back-pressure burst: in_full never rose, no write was refused");
            err_count++;
        end
        repeat (40) @(negedge clock);
        if (out_empty !== 1'b0) begin
            $display("error at %0t: out_empty = %b, expected 0", $time, out_empty);
            err_count++;
        end
        rd_mode = 1;
        wait_drain();
        report_test("backpressure", mark);

        mark    = err_count;
        rx_mark = received;
        rd_mode = 2;
        repeat (6) @(negedge clock);
        rd_mode = 1;
        if (received != rx_mark) begin
            $display("empty read: %0d results came out of an empty output FIFO",
                     received - rx_mark);
            err_count++;
        end
        if (out_empty !== 1'b1) begin
            $display("error at %0t: out_empty = %b, expected 1", $time, out_empty);
            err_count++;
        end
        if (received != accepted || sb.size() != 0) begin
            $display("count mismatch: %0d writes accepted but %0d results read",
                     accepted, received);
            err_count++;
        end
        report_test("empty_read", mark);

        $display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, checks, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- dot_top.sv
`timescale 1ns/1ps

module dot_top #(
    parameter int q_bits    = 10,
    parameter int in_depth  = 8,
    parameter int out_depth = 16
) (
    input  logic             clock,
    input  logic             reset,

    input  dot_pkg::sample_t in_x [dot_pkg::LANES],
    input  dot_pkg::sample_t in_y [dot_pkg::LANES],
    input  logic             in_wr_en,
    output logic             in_full,

    output dot_pkg::result_t out_data,
    output logic             out_empty,
    input  logic             out_rd_en
);

    dot_in_if         vec_if ();
    dot_pkg::result_t eng_result;
    logic             eng_wr_en;
    logic             out_full;

    // host pairs wait here until the engine is free
    vec_fifo #(
        .in_depth (in_depth)
    ) u_vec_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_x     (in_x),
        .wr_y     (in_y),
        .wr_en    (in_wr_en),
        .full     (in_full),
        .rd       (vec_if.fifo_side)
    );

    dot_engine #(
        .q_bits   (q_bits)
    ) u_dot_engine (
        .clock    (clock),
        .reset    (reset),
        .src      (vec_if.engine_side),
        .result   (eng_result),
        .full     (out_full),
        .wr_en    (eng_wr_en)
    );

    sync_fifo #(
        .width    ($bits(dot_pkg::result_t)),
        .depth    (out_depth)
    ) u_out_fifo (
        .clock    (clock),
        .reset    (reset),
        .din      (eng_result),
        .wr_en    (eng_wr_en),
        .full     (out_full),
        .dout     (out_data),
        .rd_en    (out_rd_en),
        .empty    (out_empty)
    );

endmodule

//--- dot_engine.sv
`timescale 1ns/1ps

module dot_engine #(
    parameter int q_bits = 10
) (
    input  logic             clock,
    input  logic             reset,
    dot_in_if.engine_side    src,
    output dot_pkg::result_t result,
    input  logic             full,
    output logic             wr_en
);

    localparam int prod_w = 2 * $bits(dot_pkg::sample_t);

    dot_pkg::engine_state_t state;
    dot_pkg::engine_state_t next_state;

    logic signed [prod_w-1:0] prod [dot_pkg::LANES];
    dot_pkg::lane_t           lane [dot_pkg::LANES];
    dot_pkg::lane_t           lane_sum;
    dot_pkg::result_t         result_c;
    logic                     load;

    // ==========================================================
    // datapath
    // ==========================================================

    // products are formed every cycle from the head pair, load picks them up
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < dot_pkg::LANES; i++) begin
            prod[i]  = src.x[i] * src.y[i];                      // full 64 bit signed product
            lane[i]  = dot_pkg::lane_t'(prod[i] >>> q_bits);     // floor back to Q format
            lane_sum = lane_sum + lane[i];
        end
        result_c = dot_pkg::result_t'(lane_sum); // keeps the low 32 bits, so the sum wraps
    end

    always_ff @(posedge clock) begin
        if (load) begin
            result <= result_c;
        end
    end

    // ==========================================================
    // control
    // ==========================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= dot_pkg::s_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        load       = 1'b0;
        src.rd_en  = 1'b0;
        wr_en      = 1'b0;

        case (state)
            dot_pkg::s_fetch: begin
                if (!src.empty) begin
                    load       = 1'b1;
                    src.rd_en  = 1'b1; // pair is consumed in the same cycle
                    next_state = dot_pkg::s_store;
                end
            end
            dot_pkg::s_store: begin
                if (!full) begin
                    wr_en      = 1'b1;
                    next_state = dot_pkg::s_fetch;
                end
            end
            default: begin
                next_state = dot_pkg::s_fetch;
            end
        endcase
    end

    // ==========================================================
    // checks
    // ==========================================================

    a_wr_in_store: assert property (
        @(posedge clock) disable iff (reset)
        wr_en |-> (state == dot_pkg::s_store) && !full
    ) else $error("dot_engine: write outside s_store or into a full FIFO");

    a_hold_on_stall: assert property (
        @(posedge clock) disable iff (reset)
        (state == dot_pkg::s_store) && full |=> $stable(result)
    ) else $error("dot_engine: result changed during back-pressure");

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [width-1:0] din,
    input  logic             wr_en,
    output logic             full,
    output logic [width-1:0] dout,
    input  logic             rd_en,
    output logic             empty
);

    localparam int aw = $clog2(depth);

    logic [width-1:0] mem [depth];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_write;
    logic          do_read;

    // ==========================================================
    // flags and accepted strobes
    // ==========================================================

    assign full     = (count == (aw+1)'(depth));
    assign empty    = (count == '0);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty; // reads on an empty FIFO change nothing

    // ==========================================================
    // storage
    // ==========================================================

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    assign dout = mem[rd_ptr]; // show-ahead, valid while empty is low

    // ==========================================================
    // pointers and occupancy
    // ==========================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==========================================================
    // checks
    // ==========================================================

    // the producer has to respect full, a dropped word would be lost silently
    a_no_write_full: assert property (
        @(posedge clock) disable iff (reset)
        wr_en |-> !full
    ) else $error("sync_fifo: wr_en raised while full");

endmodule

//--- vec_fifo.sv
`timescale 1ns/1ps

module vec_fifo #(
    parameter int in_depth = 8
) (
    input  logic             clock,
    input  logic             reset,
    input  dot_pkg::sample_t wr_x [dot_pkg::LANES],
    input  dot_pkg::sample_t wr_y [dot_pkg::LANES],
    input  logic             wr_en,
    output logic             full,
    dot_in_if.fifo_side      rd
);

    localparam int aw = $clog2(in_depth);

    dot_pkg::sample_t x_mem [in_depth][dot_pkg::LANES];
    dot_pkg::sample_t y_mem [in_depth][dot_pkg::LANES];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_write;
    logic          do_read;

    // ==========================================================
    // flags and accepted strobes
    // ==========================================================

    assign full     = (count == (aw+1)'(in_depth));
    assign rd.empty = (count == '0);
    assign do_write = wr_en && !full;      // writes into a full FIFO are dropped
    assign do_read  = rd.rd_en && !rd.empty;

    // ==========================================================
    // storage
    // ==========================================================

    always_ff @(posedge clock) begin
        if (do_write) begin
            for (int i = 0; i < dot_pkg::LANES; i++) begin
                x_mem[wr_ptr][i] <= wr_x[i];
                y_mem[wr_ptr][i] <= wr_y[i];
            end
        end
    end

    // head pair is shown whenever the FIFO holds data
    always_comb begin
        for (int i = 0; i < dot_pkg::LANES; i++) begin
            rd.x[i] = x_mem[rd_ptr][i];
            rd.y[i] = y_mem[rd_ptr][i];
        end
    end

    // ==========================================================
    // pointers and occupancy
    // ==========================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so this wraps
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle or simultaneous push and pop
            endcase
        end
    end

    // ==========================================================
    // checks
    // ==========================================================

    // the engine must only pop a pair that is actually there
    a_no_pop_empty: assert property (
        @(posedge clock) disable iff (reset)
        rd.rd_en |-> !rd.empty
    ) else $error("vec_fifo: rd_en raised while empty");

    a_count_bound: assert property (
        @(posedge clock) disable iff (reset)
        count <= (aw+1)'(in_depth)
    ) else $error("vec_fifo: occupancy above depth");

endmodule

//--- dot_in_if.sv
`timescale 1ns/1ps

interface dot_in_if;

    dot_pkg::sample_t x [dot_pkg::LANES]; // head x vector of the input FIFO
    dot_pkg::sample_t y [dot_pkg::LANES]; // head y vector of the input FIFO
    logic             empty;              // no pair available, x and y invalid
    logic             rd_en;              // pops the head pair at the clock edge

    // the FIFO presents its oldest pair and takes the pop strobe
    modport fifo_side (
        output x,
        output y,
        output empty,
        input  rd_en
    );

    // the engine reads the head pair and pops it when done
    modport engine_side (
        input  x,
        input  y,
        input  empty,
        output rd_en
    );

endinterface

//--- dot_pkg.sv
package dot_pkg;

    // ==========================================================
    // vector shape
    // ==========================================================

    localparam int LANES = 3; // elements per vector, fixed

    // ==========================================================
    // data types
    // ==========================================================

    // one vector element in signed Q format, fraction width set by q_bits
    typedef logic signed [31:0] sample_t;

    // lane product after the scale shift, wide enough for 16.16 inputs
    typedef logic signed [47:0] lane_t;

    // dot-product word as stored in the output FIFO, wraps on overflow
    typedef logic signed [31:0] result_t;

    // ==========================================================
    // engine control
    // ==========================================================

    typedef enum logic {
        s_fetch, // waiting for a vector pair
        s_store  // holding a result until the output FIFO has room
    } engine_state_t;

endpackage
